/* Makefile */
VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mipsCore.f */
verilog/mipsPkg.sv
verilog/stageReg.sv
verilog/controlUnit.sv
verilog/regFile.sv
verilog/alu.sv
verilog/mipsCore.sv
verification/mipsCore_props.sv
verification/mipsCoreTb.sv

/* verification/mipsCoreTb.sv */
// Memories are 256 words each, indexed by address bits 9:2; programs run one at a time from reset.
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

  logic        clk;
  logic        rstN;
  logic [31:0] instructionAddress;
  logic [31:0] instruction;
  logic [31:0] dataMemAddress;
  logic [31:0] dataOut;
  logic [31:0] dataIn;
  logic        memWriteEnable;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] gotAddr [$];
  logic [31:0] gotData [$];

  int errorCount;
  int cycleCount;
  int cycleLimit;

  mipsCore i_dut (
    .clk               (clk),
    .rstN              (rstN),
    .instructionAddress(instructionAddress),
    .instruction       (instruction),
    .dataMemAddress    (dataMemAddress),
    .dataOut           (dataOut),
    .dataIn            (dataIn),
    .memWriteEnable    (memWriteEnable)
  );

  always #50 clk = ~clk;

  // Fetches past the array return the all-zero no-op.
  assign instruction = (instructionAddress[31:10] == '0) ? imem[instructionAddress[9:2]] : '0;
  assign dataIn      = dmem[dataMemAddress[9:2]];

  // Stores are taken at the falling edge, where the memory stage outputs are settled.
  always @(negedge clk) begin
    if (rstN && memWriteEnable) begin
      dmem[dataMemAddress[9:2]] = dataOut;
      gotAddr.push_back(dataMemAddress);
      gotData.push_back(dataOut);
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Run stopped after %0d cycles, the DUT did not finish in time", cycleCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected data %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkAddr(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected address %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Reset, load, wait for the last store, drain, then compare.
  task automatic runProgram(input string name);
    int waited;
    @(posedge clk);
    rstN <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    gotAddr = {};
    gotData = {};
    // Budget covers program, drain and two reset cycles, doubled.
    cycleLimit += 2 * (prog.size() + 8 + 2);
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    waited = 0;
    while (gotAddr.size() < expAddr.size() && waited < prog.size() + 8) begin
      @(posedge clk);
      waited++;
    end
    repeat (8) @(posedge clk);
    if (gotAddr.size() < expAddr.size()) begin
      $display("%s: only %0d of %0d expected stores happened", name, gotAddr.size(),
               expAddr.size());
      errorCount++;
    end else if (gotAddr.size() > expAddr.size()) begin
      $display("%s: %0d stores happened where %0d were expected", name, gotAddr.size(),
               expAddr.size());
      errorCount++;
    end
    foreach (expAddr[i]) begin
      if (i < gotAddr.size()) begin
        checkAddr(name, expAddr[i], gotAddr[i]);
        checkWord(name, expData[i], gotData[i]);
      end
      checkWord(name, expData[i], dmem[expAddr[i][9:2]]);
    end
    prog    = {};
    expAddr = {};
    expData = {};
  endtask

  task automatic testArithmetic();
    logic [15:0] immA;
    logic [15:0] immB;
    logic [31:0] a;
    logic [31:0] b;
    immA = 16'($urandom);
    immB = 16'($urandom);
    a    = {{16{immA[15]}}, immA};
    b    = {{16{immB[15]}}, immB};
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, immA));
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd2, immB));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(rWord(5'd1, 5'd2, 5'd3, mipsPkg::fnAdd));
    prog.push_back(rWord(5'd1, 5'd2, 5'd4, mipsPkg::fnSub));
    prog.push_back(rWord(5'd1, 5'd2, 5'd5, mipsPkg::fnAnd));
    prog.push_back(rWord(5'd1, 5'd2, 5'd6, mipsPkg::fnOr));
    prog.push_back(rWord(5'd1, 5'd2, 5'd7, mipsPkg::fnSlt));
    for (int r = 3; r <= 7; r++) begin
      prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'(r), 16'(16 + 4 * (r - 3))));
    end
    expectStore(32'h10, a + b);
    expectStore(32'h14, a - b);
    expectStore(32'h18, a & b);
    expectStore(32'h1c, a | b);
    // Signed order follows the sign bits, or the magnitudes when the signs agree.
    expectStore(32'h20, {31'd0, (a[31] != b[31]) ? a[31] : (a < b)});
    runProgram("arithmetic");
  endtask

  task automatic testLoadStore();
    logic [15:0] imm;
    imm = 16'($urandom);
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, imm));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h40));
    prog.push_back(iWord(mipsPkg::opLw, 5'd0, 5'd2, 16'h40));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd2, 16'h44));
    expectStore(32'h40, {{16{imm[15]}}, imm});
    expectStore(32'h44, {{16{imm[15]}}, imm});
    runProgram("loadStore");
  endtask

  task automatic testBranchTaken();
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5));
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd2, 16'd5));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    // Target is word 10, five words past the following instruction.
    prog.push_back(iWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd5));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h60));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h64));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h68));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h6c));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h70));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd2, 16'h74));
    expectStore(32'h60, 32'd5);
    expectStore(32'h64, 32'd5);
    expectStore(32'h68, 32'd5);
    expectStore(32'h74, 32'd5);
    runProgram("branchTaken");
  endtask

  task automatic testBranchNotTaken();
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, 16'd3));
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd2, 16'd7));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(iWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd4));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h80));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd2, 16'h84));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h88));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd2, 16'h8c));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h90));
    expectStore(32'h80, 32'd3);
    expectStore(32'h84, 32'd7);
    expectStore(32'h88, 32'd3);
    expectStore(32'h8c, 32'd7);
    expectStore(32'h90, 32'd3);
    runProgram("branchNotTaken");
  endtask

  task automatic testRegZero();
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd0, 16'h123));
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, 16'h55));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(rWord(5'd1, 5'd1, 5'd0, mipsPkg::fnAdd));
    prog.push_back(32'd0);
    prog.push_back(32'd0);
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd0, 16'ha0));
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'ha4));
    expectStore(32'ha0, 32'd0);
    expectStore(32'ha4, 32'h55);
    runProgram("regZero");
  endtask

  task automatic testUndefined();
    prog.push_back(iWord(mipsPkg::opAddi, 5'd0, 5'd1, 16'h11));
    // Unknown opcode, zero word, unknown function code, then a jump.
    prog.push_back(iWord(6'h3f, 5'd0, 5'd1, 16'h7777));
    prog.push_back(32'd0);
    prog.push_back(rWord(5'd0, 5'd0, 5'd1, 6'h3f));
    prog.push_back(iWord(6'h02, 5'd0, 5'd1, 16'h0001));
    prog.push_back(32'd0);
    prog.push_back(iWord(mipsPkg::opSw, 5'd0, 5'd1, 16'hc0));
    expectStore(32'hc0, 32'h11);
    runProgram("undefined");
  endtask

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    errorCount = 0;
    cycleCount = 0;
    cycleLimit = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    void'($urandom(78));
    testArithmetic();
    testLoadStore();
    testBranchTaken();
    testBranchNotTaken();
    testRegZero();
    testUndefined();
    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/mipsCore_props.sv */
// Checks only port-level behavior; evaluation stops while reset is held except at its release.
`timescale 1ns/1ps
`default_nettype none

module mipsCoreProps (
  input wire logic        clk,
  input wire logic        rstN,
  input wire logic [31:0] instructionAddress,
  input wire logic [31:0] dataMemAddress,
  input wire logic [31:0] dataOut,
  input wire logic        memWriteEnable
);

  // First cycle after reset is a bubble.
  noStoreAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !memWriteEnable)
    else $error("store issued in the first cycle after reset");

  startAtResetPc: assert property (
    @(posedge clk) $rose(rstN) |-> instructionAddress == mipsPkg::resetPc)
    else $error("fetch did not start at the reset address");

  storeKnown: assert property (@(posedge clk) disable iff (!rstN)
    memWriteEnable |-> !$isunknown({dataOut, dataMemAddress}))
    else $error("store with unknown address or data");

  fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
    instructionAddress[1:0] == 2'b00)
    else $error("unaligned fetch address");

endmodule

bind mipsCore mipsCoreProps props (
  .clk               (clk),
  .rstN              (rstN),
  .instructionAddress(instructionAddress),
  .dataMemAddress    (dataMemAddress),
  .dataOut           (dataOut),
  .memWriteEnable    (memWriteEnable)
);

`default_nettype wire

/* verilog/alu.sv */
// Purely combinational; set-less-than compares as signed and unknown ops give zero.
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire logic [31:0]    operandA,
  input  wire logic [31:0]    operandB,
  input  wire mipsPkg::aluOpT aluOp,
  output logic      [31:0]    result,
  output logic                zero
);

  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: result = operandA + operandB;
      mipsPkg::aluSub: result = operandA - operandB;
      mipsPkg::aluAnd: result = operandA & operandB;
      mipsPkg::aluOr:  result = operandA | operandB;
      mipsPkg::aluSlt: begin
        result = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
      end
      default: result = '0;
    endcase
  end

  // Beq uses this with a subtract.
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
// Decodes only the nine supported instructions; any other word gives the all-zero no-op.
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  wire logic [31:0]  instruction,
  output mipsPkg::ctrlT     ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instruction[31:26];
  assign funct  = instruction[5:0];

  always_comb begin
    ctrl = '0;
    case (opcode)
      mipsPkg::opRType: begin
        // Unknown function codes stay a no-op, including the all-zero word.
        case (funct)
          mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  ctrl.aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
          default:        ctrl.aluOp = mipsPkg::aluAdd;
        endcase
        if (funct == mipsPkg::fnAdd || funct == mipsPkg::fnSub ||
            funct == mipsPkg::fnAnd || funct == mipsPkg::fnOr ||
            funct == mipsPkg::fnSlt) begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst   = 1'b1;
        end
      end
      mipsPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = mipsPkg::aluAdd;
      end
      mipsPkg::opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = mipsPkg::aluAdd;
      end
      mipsPkg::opBeq: begin
        // Equality shows up as a zero difference.
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = mipsPkg::aluAdd;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/mipsCore.sv */
// No hazard detection, forwarding or flush; the three words after a beq always execute.
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
  input  wire logic        clk,
  input  wire logic        rstN,
  output logic      [31:0] instructionAddress,
  input  wire logic [31:0] instruction,
  output logic      [31:0] dataMemAddress,
  output logic      [31:0] dataOut,
  input  wire logic [31:0] dataIn,
  output logic             memWriteEnable
);

  // Fetch.
  logic [31:0] pc;
  logic [31:0] pcNext;
  logic [31:0] pcPlus4If;
  logic        pcSource;

  // Stage registers.
  mipsPkg::ifIdT  ifIdD;
  mipsPkg::ifIdT  ifIdQ;
  mipsPkg::idExT  idExD;
  mipsPkg::idExT  idExQ;
  mipsPkg::exMemT exMemD;
  mipsPkg::exMemT exMemQ;
  mipsPkg::memWbT memWbD;
  mipsPkg::memWbT memWbQ;

  // Decode.
  mipsPkg::ctrlT ctrlId;
  logic [31:0]   readData1Id;
  logic [31:0]   readData2Id;

  // Execute.
  logic [31:0] aluOperandB;
  logic [31:0] aluResultEx;
  logic        zeroEx;
  logic [4:0]  writeRegEx;
  logic [31:0] branchTargetEx;

  // Write-back.
  logic [31:0] resultWb;

  // Program counter.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= mipsPkg::resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  assign pcPlus4If          = pc + 32'd4;
  // Taken branch is decided from the memory stage register.
  assign pcSource           = exMemQ.branch & exMemQ.zero;
  assign pcNext             = pcSource ? exMemQ.branchTarget : pcPlus4If;
  assign instructionAddress = pc;

  assign ifIdD.instr   = instruction;
  assign ifIdD.pcPlus4 = pcPlus4If;

  stageReg #(.T(mipsPkg::ifIdT)) ifIdStage (
    .clk (clk),
    .rstN(rstN),
    .d   (ifIdD),
    .q   (ifIdQ)
  );

  controlUnit decoder (
    .instruction(ifIdQ.instr),
    .ctrl       (ctrlId)
  );

  regFile registers (
    .clk        (clk),
    .rstN       (rstN),
    .readReg1   (ifIdQ.instr[25:21]),
    .readReg2   (ifIdQ.instr[20:16]),
    .readData1  (readData1Id),
    .readData2  (readData2Id),
    .writeEnable(memWbQ.regWrite),
    .writeReg   (memWbQ.writeReg),
    .writeData  (resultWb)
  );

  assign idExD.ctrl      = ctrlId;
  assign idExD.readData1 = readData1Id;
  assign idExD.readData2 = readData2Id;
  assign idExD.rt        = ifIdQ.instr[20:16];
  assign idExD.rd        = ifIdQ.instr[15:11];
  // Sign extension of the 16-bit immediate.
  assign idExD.signImm   = {{16{ifIdQ.instr[15]}}, ifIdQ.instr[15:0]};
  assign idExD.pcPlus4   = ifIdQ.pcPlus4;

  stageReg #(.T(mipsPkg::idExT)) idExStage (
    .clk (clk),
    .rstN(rstN),
    .d   (idExD),
    .q   (idExQ)
  );

  assign writeRegEx  = idExQ.ctrl.regDst ? idExQ.rd : idExQ.rt;
  assign aluOperandB = idExQ.ctrl.aluSrc ? idExQ.signImm : idExQ.readData2;

  alu mainAlu (
    .operandA(idExQ.readData1),
    .operandB(aluOperandB),
    .aluOp   (idExQ.ctrl.aluOp),
    .result  (aluResultEx),
    .zero    (zeroEx)
  );

  // Word offset relative to the following instruction.
  assign branchTargetEx = idExQ.pcPlus4 + {idExQ.signImm[29:0], 2'b00};

  assign exMemD.regWrite     = idExQ.ctrl.regWrite;
  assign exMemD.memToReg     = idExQ.ctrl.memToReg;
  assign exMemD.memWrite     = idExQ.ctrl.memWrite;
  assign exMemD.branch       = idExQ.ctrl.branch;
  assign exMemD.zero         = zeroEx;
  assign exMemD.aluResult    = aluResultEx;
  assign exMemD.storeData    = idExQ.readData2;
  assign exMemD.writeReg     = writeRegEx;
  assign exMemD.branchTarget = branchTargetEx;

  stageReg #(.T(mipsPkg::exMemT)) exMemStage (
    .clk (clk),
    .rstN(rstN),
    .d   (exMemD),
    .q   (exMemQ)
  );

  // Data memory is driven straight from the register.
  assign dataMemAddress = exMemQ.aluResult;
  assign dataOut        = exMemQ.storeData;
  assign memWriteEnable = exMemQ.memWrite;

  assign memWbD.regWrite  = exMemQ.regWrite;
  assign memWbD.memToReg  = exMemQ.memToReg;
  assign memWbD.aluResult = exMemQ.aluResult;
  assign memWbD.loadData  = dataIn;
  assign memWbD.writeReg  = exMemQ.writeReg;

  stageReg #(.T(mipsPkg::memWbT)) memWbStage (
    .clk (clk),
    .rstN(rstN),
    .d   (memWbD),
    .q   (memWbQ)
  );

  assign resultWb = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

endmodule

`default_nettype wire

/* verilog/mipsPkg.sv */
// Encodings cover only add, sub, and, or, slt, addi, lw, sw and beq; an all-zero struct is a bubble.
`default_nettype none

package mipsPkg;

  // Major opcodes.
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opAddi  = 6'h08;

  // Function field of R-type words.
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // First fetch address.
  localparam logic [31:0] resetPc = 32'h0000_0000;

  // Add is the zero encoding, so a cleared struct still selects a legal op.
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  // Decoded control bits.
  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memWrite;
    logic  branch;
    logic  aluSrc;
    logic  regDst;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pcPlus4;
  } ifIdT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] signImm;
    logic [31:0] pcPlus4;
  } idExT;

  // Only the controls still needed past execute.
  typedef struct packed {
    logic        regWrite;
    logic        memToReg;
    logic        memWrite;
    logic        branch;
    logic        zero;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [4:0]  writeReg;
    logic [31:0] branchTarget;
  } exMemT;

  typedef struct packed {
    logic        regWrite;
    logic        memToReg;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [4:0]  writeReg;
  } memWbT;

endpackage

`default_nettype wire

/* verilog/regFile.sv */
// Register zero always reads zero; a read of the register written this cycle returns the new value.
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic        clk,
  input  wire logic        rstN,
  input  wire logic [4:0]  readReg1,
  input  wire logic [4:0]  readReg2,
  output logic      [31:0] readData1,
  output logic      [31:0] readData2,
  input  wire logic        writeEnable,
  input  wire logic [4:0]  writeReg,
  input  wire logic [31:0] writeData
);

  // Register zero has no storage.
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeReg != 5'd0) begin
      regs[writeReg] <= writeData;
    end
  end

  // Write-through lets decode see a write-back in the same cycle.
  assign readData1 = (readReg1 == 5'd0) ? 32'd0 :
                     (writeEnable && writeReg == readReg1) ? writeData :
                     regs[readReg1];

  assign readData2 = (readReg2 == 5'd0) ? 32'd0 :
                     (writeEnable && writeReg == readReg2) ? writeData :
                     regs[readReg2];

endmodule

`default_nettype wire

/* verilog/stageReg.sv */
// Captures every cycle with no enable or stall; reset clears the whole payload to zero.
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
  parameter type T = logic [31:0]
) (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire T     d,
  output T          q
);

  // A cleared payload is a bubble in every stage.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire
